/* sram_axi_bridge.f */
src/axi_bridge_pkg.sv
src/bridge_fsm.sv
src/beat_counter.sv
src/write_line_buffer.sv
src/sram_axi_bridge.sv
bench/axi_slave_model.sv
bench/sram_axi_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sram_axi_bridge testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module sram_axi_bridge_tb \
    -f sram_axi_bridge.f -Mdir obj_dir -o sim_bridge
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bridge > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* bench/sram_axi_bridge_tb.sv */
module sram_axi_bridge_tb import axi_bridge_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int         CLK_PERIOD   = 40;
    localparam int         RESET_CYCLES = 16;
    // 6 tests of 20 beats at 5 cycles per beat plus reset
    localparam int         TIMEOUT_NS   = (6 * 20 * 5 + RESET_CYCLES) * CLK_PERIOD;
    localparam word_t      FILL_KEY     = 32'h5EED_0000;
    localparam xfer_type_t XFER_WORD    = 3'b010;

    logic       aclk, reset;
    logic       inst_ce, inst_we, inst_rdata_valid, inst_write_finish;
    logic       data_ce, data_we, data_rdata_valid, data_write_finish;
    addr_t      inst_addr, data_addr, ar_addr, aw_addr;
    xfer_type_t inst_transfer_type, data_transfer_type;
    line_t      inst_wdata, data_wdata;
    line_mask_t inst_wmask, data_wmask;
    word_t      inst_rdata, data_rdata, rd_data, wd_data;
    logic       ar_valid, ar_ready, rd_valid, rd_ready, rd_last;
    logic       aw_valid, aw_ready, wd_valid, wd_ready, wd_last, wr_valid, wr_ready;
    burst_len_t ar_len, aw_len;
    strb_t      wstrb;

    // expected slave memory after the preset and every masked write
    word_t exp_mem [0:1023];
    word_t inst_beats [$];
    word_t data_beats [$];
    // per read beat flag set for the data port
    bit    beat_from_data [$];
    int    inst_acks;
    int    data_acks;
    int    inst_finishes;
    int    data_finishes;
    int    errors;
    int    tests_run;
    int    tests_failed;

    sram_axi_bridge UUT (.*);

    axi_slave_model #(.FILL_KEY(FILL_KEY)) slave (.*);

    initial begin
        aclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) aclk = ~aclk;
        end
    end

    // completions sampled on the rising edge of their handshake
    always @(posedge aclk) begin
        if (reset) begin
            if (data_rdata_valid) begin
                data_beats.push_back(data_rdata);
                beat_from_data.push_back(1'b1);
                data_acks += int'(rd_last);
            end
            if (inst_rdata_valid) begin
                inst_beats.push_back(inst_rdata);
                beat_from_data.push_back(1'b0);
                inst_acks += int'(rd_last);
            end
            data_finishes += int'(data_write_finish);
            inst_finishes += int'(inst_write_finish);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    task automatic clear_logs();
        inst_beats.delete();
        data_beats.delete();
        beat_from_data.delete();
        slave.ar_addr_log.delete();
        slave.ar_len_log.delete();
        slave.aw_len_log.delete();
        inst_finishes = 0;
        data_finishes = 0;
    endtask

    // requester pins of one port
    task automatic drive_port(input bit to_data, input bit ce, input bit we, input addr_t addr,
                              input bit line, input line_t wdata, input line_mask_t wmask);
        xfer_type_t code;
        code = line ? XFER_LINE : XFER_WORD;
        if (to_data) begin
            data_ce            = ce;
            data_we            = we;
            data_addr          = addr;
            data_transfer_type = code;
            data_wdata         = wdata;
            data_wmask         = wmask;
        end else begin
            inst_ce            = ce;
            inst_we            = we;
            inst_addr          = addr;
            inst_transfer_type = code;
            inst_wdata         = wdata;
            inst_wmask         = wmask;
        end
    endtask

    // four-phase read that may hold ce past the acknowledge
    task automatic read_request(input bit to_data, input addr_t addr, input bit line,
                                input int hold_cycles);
        int acks_before;
        acks_before = to_data ? data_acks : inst_acks;
        drive_port(to_data, 1'b1, 1'b0, addr, line, '0, '0);
        // last read beat is the acknowledge
        while ((to_data ? data_acks : inst_acks) == acks_before) begin
            @(negedge aclk);
        end
        repeat (hold_cycles) begin
            @(negedge aclk);
            if (ar_valid || aw_valid) begin
                $display("bridge started a new transaction while ce was still held");
                errors++;
            end
        end
        drive_port(to_data, 1'b0, 1'b0, addr, line, '0, '0);
        @(negedge aclk);
    endtask

    task automatic write_request(input bit to_data, input addr_t addr, input bit line,
                                 input line_t wdata, input line_mask_t wmask);
        int finishes_before;
        int idx;
        finishes_before = to_data ? data_finishes : inst_finishes;
        drive_port(to_data, 1'b1, 1'b1, addr, line, wdata, wmask);
        while ((to_data ? data_finishes : inst_finishes) == finishes_before) begin
            @(negedge aclk);
        end
        drive_port(to_data, 1'b0, 1'b1, addr, line, wdata, wmask);
        @(negedge aclk);
        // masked bytes replace the old ones word by word from the line bottom
        for (int b = 0; b < (line ? BEATS_PER_LINE : 1); b++) begin
            idx = (int'(addr[11:2]) + b) % 1024;
            for (int k = 0; k < 4; k++) begin
                if (wmask[4 * b + k]) begin
                    exp_mem[idx][8 * k +: 8] = wdata[32 * b + 8 * k +: 8];
                end
            end
        end
    endtask

    task automatic check_read_beats(input string name, input bit from_data, input addr_t addr,
                                    input int count);
        int    n;
        int    idx;
        word_t actual;
        n = from_data ? data_beats.size() : inst_beats.size();
        if (n != count) begin
            report_mismatch({name, " beat count"}, count, n);
        end else begin
            for (int b = 0; b < count; b++) begin
                idx = (int'(addr[11:2]) + b) % 1024;
                actual = from_data ? data_beats[b] : inst_beats[b];
                if (actual !== exp_mem[idx]) begin
                    report_mismatch({name, " beat data"}, exp_mem[idx], actual);
                end
            end
        end
    endtask

    task automatic check_len(input string name, input bit write_side, input burst_len_t expected);
        int         seen;
        burst_len_t logged;
        seen = write_side ? slave.aw_len_log.size() : slave.ar_len_log.size();
        if (seen != 1) begin
            $display("%s: slave received %0d addresses instead of one", name, seen);
            errors++;
        end else begin
            logged = write_side ? slave.aw_len_log[0] : slave.ar_len_log[0];
            if (logged != expected) begin
                report_mismatch({name, " len"}, 32'(expected), 32'(logged));
            end
        end
    endtask

    task automatic close_test(input string name, input int start_errors);
        // write channel faults the slave flagged during this test
        errors += slave.protocol_errors;
        slave.protocol_errors = 0;
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic single_data_read_test();
        int start_errors;
        start_errors = errors;
        clear_logs();
        read_request(1'b1, 32'h0000_0040, 1'b0, 0);
        check_read_beats("single_data_read", 1'b1, 32'h0000_0040, 1);
        check_read_beats("single_data_read inst", 1'b0, 32'h0000_0040, 0);
        check_len("single_data_read", 1'b0, 8'd0);
        close_test("single_data_read", start_errors);
    endtask

    task automatic line_inst_read_test();
        int start_errors;
        start_errors = errors;
        clear_logs();
        read_request(1'b0, 32'h0000_0100, 1'b1, 0);
        check_read_beats("line_inst_read", 1'b0, 32'h0000_0100, BEATS_PER_LINE);
        check_read_beats("line_inst_read data", 1'b1, 32'h0000_0100, 0);
        check_len("line_inst_read", 1'b0, 8'd15);
        close_test("line_inst_read", start_errors);
    endtask

    task automatic line_data_write_test();
        int         start_errors;
        line_t      wdata;
        line_mask_t wmask;
        start_errors = errors;
        clear_logs();
        for (int w = 0; w < BEATS_PER_LINE; w++) begin
            wdata[32 * w +: 32] = $urandom;
        end
        // whole words mixed with single bytes and untouched words
        wmask = 64'h0F3C_FF00_A5A5_0FF1;
        write_request(1'b1, 32'h0000_0200, 1'b1, wdata, wmask);
        if (data_finishes != 1) report_mismatch("line_data_write finish", 1, data_finishes);
        if (inst_finishes != 0) report_mismatch("line_data_write inst finish", 0, inst_finishes);
        check_len("line_data_write", 1'b1, 8'd15);
        clear_logs();
        read_request(1'b1, 32'h0000_0200, 1'b1, 0);
        check_read_beats("line_data_write readback", 1'b1, 32'h0000_0200, BEATS_PER_LINE);
        close_test("line_data_write", start_errors);
    endtask

    task automatic single_inst_write_test();
        int    start_errors;
        line_t wdata;
        start_errors = errors;
        clear_logs();
        wdata = '0;
        wdata[31:0] = $urandom;
        write_request(1'b0, 32'h0000_0344, 1'b0, wdata, 64'hF);
        if (inst_finishes != 1) report_mismatch("single_inst_write finish", 1, inst_finishes);
        if (data_finishes != 0) report_mismatch("single_inst_write data finish", 0, data_finishes);
        check_len("single_inst_write", 1'b1, 8'd0);
        clear_logs();
        read_request(1'b0, 32'h0000_0344, 1'b0, 0);
        check_read_beats("single_inst_write readback", 1'b0, 32'h0000_0344, 1);
        close_test("single_inst_write", start_errors);
    endtask

    task automatic simultaneous_reads_test();
        int start_errors;
        bit inst_seen;
        start_errors = errors;
        clear_logs();
        // both ce rise on the same falling edge
        fork
            read_request(1'b1, 32'h0000_0080, 1'b0, 0);
            read_request(1'b0, 32'h0000_0180, 1'b1, 0);
        join
        if (slave.ar_addr_log.size() != 2) begin
            $display("simultaneous_reads: slave did not receive two read addresses");
            errors++;
        end else if (slave.ar_addr_log[0] != 32'h0000_0080) begin
            report_mismatch("simultaneous_reads first address", 32'h80, slave.ar_addr_log[0]);
        end
        inst_seen = 1'b0;
        foreach (beat_from_data[i]) begin
            if (beat_from_data[i] && inst_seen) begin
                $display("simultaneous_reads: data beat arrived after an instruction beat");
                errors++;
            end
            inst_seen = inst_seen | ~beat_from_data[i];
        end
        check_read_beats("simultaneous_reads data", 1'b1, 32'h0000_0080, 1);
        check_read_beats("simultaneous_reads inst", 1'b0, 32'h0000_0180, BEATS_PER_LINE);
        close_test("simultaneous_reads", start_errors);
    endtask

    task automatic held_ce_test();
        int start_errors;
        start_errors = errors;
        clear_logs();
        read_request(1'b0, 32'h0000_0020, 1'b0, 8);
        check_read_beats("held_ce first", 1'b0, 32'h0000_0020, 1);
        check_len("held_ce first", 1'b0, 8'd0);
        clear_logs();
        read_request(1'b0, 32'h0000_0024, 1'b0, 0);
        check_read_beats("held_ce second", 1'b0, 32'h0000_0024, 1);
        close_test("held_ce", start_errors);
    endtask

    initial begin
        void'($urandom(57));
        reset = 1'b0;
        drive_port(1'b0, 1'b0, 1'b0, '0, 1'b0, '0, '0);
        drive_port(1'b1, 1'b0, 1'b0, '0, 1'b0, '0, '0);
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < 1024; i++) begin
            exp_mem[i] = word_t'(i) ^ FILL_KEY;
        end
        repeat (RESET_CYCLES) @(negedge aclk);
        reset = 1'b1;
        @(negedge aclk);
        single_data_read_test();
        line_inst_read_test();
        line_data_write_test();
        single_inst_write_test();
        simultaneous_reads_test();
        held_ce_test();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* bench/axi_slave_model.sv */
module axi_slave_model import axi_bridge_pkg::*; #(
    parameter word_t FILL_KEY = '0
) (
    input  logic       aclk,
    input  logic       reset,
    input  logic       ar_valid,
    output logic       ar_ready,
    input  addr_t      ar_addr,
    input  burst_len_t ar_len,
    output logic       rd_valid,
    input  logic       rd_ready,
    output word_t      rd_data,
    output logic       rd_last,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  addr_t      aw_addr,
    input  burst_len_t aw_len,
    input  logic       wd_valid,
    output logic       wd_ready,
    input  word_t      wd_data,
    input  strb_t      wstrb,
    input  logic       wd_last,
    output logic       wr_valid,
    input  logic       wr_ready
);
    timeunit 1ns;
    timeprecision 1ns;

    // 1024 words, indexed by byte address bits 11:2
    word_t      mem [0:1023];
    // every address the slave accepted, oldest first
    addr_t      ar_addr_log [$];
    burst_len_t ar_len_log [$];
    burst_len_t aw_len_log [$];
    int         protocol_errors;

    // random 0 to 3 cycle delay before each handshake
    task automatic stall();
        repeat ($urandom % 4) @(negedge aclk);
    endtask

    task automatic serve_read();
        logic [9:0] idx;
        burst_len_t len;
        stall();
        ar_ready = 1'b1;
        idx = ar_addr[11:2];
        len = ar_len;
        ar_addr_log.push_back(ar_addr);
        ar_len_log.push_back(ar_len);
        // valid is already high, so the next rising edge takes the address
        @(negedge aclk);
        ar_ready = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            stall();
            rd_valid = 1'b1;
            rd_data  = mem[idx];
            rd_last  = (b == int'(len));
            while (!rd_ready) @(negedge aclk);
            @(negedge aclk);
            rd_valid = 1'b0;
            rd_last  = 1'b0;
            idx      = idx + 10'd1;
        end
    endtask

    task automatic serve_write();
        logic [9:0] idx;
        burst_len_t len;
        stall();
        aw_ready = 1'b1;
        idx = aw_addr[11:2];
        len = aw_len;
        aw_len_log.push_back(aw_len);
        @(negedge aclk);
        aw_ready = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            while (!wd_valid) @(negedge aclk);
            stall();
            wd_ready = 1'b1;
            // data and strobes are stable until the coming rising edge
            for (int k = 0; k < 4; k++) begin
                if (wstrb[k]) begin
                    mem[idx][8 * k +: 8] = wd_data[8 * k +: 8];
                end
            end
            if (wd_last != (b == int'(len))) begin
                $display("slave: wd_last wrong on beat %0d of %0d", b, int'(len) + 1);
                protocol_errors++;
            end
            @(negedge aclk);
            wd_ready = 1'b0;
            idx      = idx + 10'd1;
        end
        stall();
        wr_valid = 1'b1;
        while (!wr_ready) @(negedge aclk);
        @(negedge aclk);
        wr_valid = 1'b0;
    endtask

    initial begin
        ar_ready = 1'b0;
        rd_valid = 1'b0;
        rd_data  = '0;
        rd_last  = 1'b0;
        aw_ready = 1'b0;
        wd_ready = 1'b0;
        wr_valid = 1'b0;
        protocol_errors = 0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = word_t'(i) ^ FILL_KEY;
        end
        wait (reset === 1'b1);
        // one transaction at a time, checked on falling edges
        forever begin
            @(negedge aclk);
            if (ar_valid === 1'b1) begin
                serve_read();
            end else if (aw_valid === 1'b1) begin
                serve_write();
            end
        end
    end

endmodule

/* src/sram_axi_bridge.sv */
module sram_axi_bridge import axi_bridge_pkg::*; (
    input  logic       aclk,
    input  logic       reset,
    // instruction port
    input  logic       inst_ce,
    input  logic       inst_we,
    input  addr_t      inst_addr,
    input  xfer_type_t inst_transfer_type,
    input  line_t      inst_wdata,
    input  line_mask_t inst_wmask,
    output word_t      inst_rdata,
    output logic       inst_rdata_valid,
    output logic       inst_write_finish,
    // data port
    input  logic       data_ce,
    input  logic       data_we,
    input  addr_t      data_addr,
    input  xfer_type_t data_transfer_type,
    input  line_t      data_wdata,
    input  line_mask_t data_wmask,
    output word_t      data_rdata,
    output logic       data_rdata_valid,
    output logic       data_write_finish,
    // read address channel
    output logic       ar_valid,
    input  logic       ar_ready,
    output addr_t      ar_addr,
    output burst_len_t ar_len,
    // read data channel
    input  logic       rd_valid,
    output logic       rd_ready,
    input  word_t      rd_data,
    input  logic       rd_last,
    // write address channel
    output logic       aw_valid,
    input  logic       aw_ready,
    output addr_t      aw_addr,
    output burst_len_t aw_len,
    // write data channel
    output logic       wd_valid,
    input  logic       wd_ready,
    output word_t      wd_data,
    output strb_t      wstrb,
    output logic       wd_last,
    // write response channel
    input  logic       wr_valid,
    output logic       wr_ready
);

    logic       line_load;
    logic       line_shift;
    line_t      load_line;
    line_mask_t load_mask;
    burst_len_t load_len;
    logic       beat_last;

    // read data is shared, the valids say who it belongs to
    assign inst_rdata = rd_data;
    assign data_rdata = rd_data;

    bridge_fsm u_fsm (
        .aclk(aclk), .reset(reset),
        .inst_ce(inst_ce), .inst_we(inst_we), .data_ce(data_ce), .data_we(data_we),
        .inst_addr(inst_addr), .data_addr(data_addr),
        .inst_transfer_type(inst_transfer_type), .data_transfer_type(data_transfer_type),
        .inst_wdata(inst_wdata), .data_wdata(data_wdata),
        .inst_wmask(inst_wmask), .data_wmask(data_wmask),
        .ar_ready(ar_ready), .rd_valid(rd_valid), .rd_last(rd_last),
        .aw_ready(aw_ready), .wd_ready(wd_ready), .wr_valid(wr_valid),
        .beat_last(beat_last),
        .ar_valid(ar_valid), .rd_ready(rd_ready), .aw_valid(aw_valid),
        .wd_valid(wd_valid), .wd_last(wd_last), .wr_ready(wr_ready),
        .ar_addr(ar_addr), .aw_addr(aw_addr), .ar_len(ar_len), .aw_len(aw_len),
        .inst_rdata_valid(inst_rdata_valid), .data_rdata_valid(data_rdata_valid),
        .inst_write_finish(inst_write_finish), .data_write_finish(data_write_finish),
        .line_load(line_load), .line_shift(line_shift),
        .load_line(load_line), .load_mask(load_mask), .load_len(load_len)
    );

    // counter steps on the same accepted beat that shifts the buffer
    beat_counter u_beat_counter (
        .aclk(aclk), .reset(reset),
        .load(line_load), .load_len(load_len),
        .step(line_shift),
        .beat_last(beat_last)
    );

    write_line_buffer u_line_buffer (
        .aclk(aclk), .reset(reset),
        .load(line_load), .shift(line_shift),
        .load_line(load_line), .load_mask(load_mask),
        .wd_data(wd_data), .wstrb(wstrb)
    );

endmodule

/* src/write_line_buffer.sv */
module write_line_buffer import axi_bridge_pkg::*; (
    input  logic       aclk,
    input  logic       reset,
    input  logic       load,
    input  logic       shift,
    input  line_t      load_line,
    input  line_mask_t load_mask,
    output word_t      wd_data,
    output strb_t      wstrb
);

    line_t      line_buf;
    line_mask_t mask_buf;

    // lowest word of the line goes out first
    always_ff @(posedge aclk) begin
        if (load) begin
            line_buf <= load_line;
        end else if (shift) begin
            line_buf <= {{WORD_WIDTH{1'b0}}, line_buf[LINE_WIDTH-1:WORD_WIDTH]};
        end
    end

    // byte mask moves with the data
    always_ff @(posedge aclk) begin
        if (!reset) begin
            mask_buf <= '0;
        end else if (load) begin
            mask_buf <= load_mask;
        end else if (shift) begin
            mask_buf <= {{STRB_WIDTH{1'b0}}, mask_buf[MASK_WIDTH-1:STRB_WIDTH]};
        end
    end

    // bottom word and strobe group drive the w channel
    assign wd_data = line_buf[WORD_WIDTH-1:0];
    assign wstrb   = mask_buf[STRB_WIDTH-1:0];

endmodule

/* src/beat_counter.sv */
module beat_counter import axi_bridge_pkg::*; (
    input  logic       aclk,
    input  logic       reset,
    input  logic       load,
    input  burst_len_t load_len,
    input  logic       step,
    output logic       beat_last
);

    // beats still to go after the current one
    burst_len_t count;

    always_ff @(posedge aclk) begin
        if (!reset) begin
            count <= '0;
        end else if (load) begin
            count <= load_len;
        end else if (step && count != '0) begin
            // stop at zero, no wrap after the last beat
            count <= count - 1'b1;
        end
    end

    // purely from the count, no added latency
    assign beat_last = (count == '0);

endmodule

/* src/bridge_fsm.sv */
module bridge_fsm import axi_bridge_pkg::*; (
    input  logic       aclk,
    input  logic       reset,
    // requester side
    input  logic       inst_ce,
    input  logic       inst_we,
    input  logic       data_ce,
    input  logic       data_we,
    input  addr_t      inst_addr,
    input  addr_t      data_addr,
    input  xfer_type_t inst_transfer_type,
    input  xfer_type_t data_transfer_type,
    input  line_t      inst_wdata,
    input  line_t      data_wdata,
    input  line_mask_t inst_wmask,
    input  line_mask_t data_wmask,
    // axi responses and readies
    input  logic       ar_ready,
    input  logic       rd_valid,
    input  logic       rd_last,
    input  logic       aw_ready,
    input  logic       wd_ready,
    input  logic       wr_valid,
    // from the write beat counter
    input  logic       beat_last,
    // axi control
    output logic       ar_valid,
    output logic       rd_ready,
    output logic       aw_valid,
    output logic       wd_valid,
    output logic       wd_last,
    output logic       wr_ready,
    output addr_t      ar_addr,
    output addr_t      aw_addr,
    output burst_len_t ar_len,
    output burst_len_t aw_len,
    // completion back to the requesters
    output logic       inst_rdata_valid,
    output logic       data_rdata_valid,
    output logic       inst_write_finish,
    output logic       data_write_finish,
    // write line buffer and beat counter controls
    output logic       line_load,
    output logic       line_shift,
    output line_t      load_line,
    output line_mask_t load_mask,
    output burst_len_t load_len
);

    bridge_state_t state;
    bridge_state_t state_next;

    // owner tag, high when the data port holds the bus
    logic       owner_data;
    addr_t      req_addr;
    burst_len_t req_len;

    // request picked in idle, data port wins a tie
    logic       grant;
    logic       sel_data;
    logic       sel_we;
    addr_t      sel_addr;
    xfer_type_t sel_type;
    logic       owner_ce;

    // handshake strobes
    logic ar_fire;
    logic aw_fire;
    logic wd_fire;
    logic rd_fire;

    assign grant    = data_ce | inst_ce;
    assign sel_data = data_ce;
    assign sel_we   = sel_data ? data_we            : inst_we;
    assign sel_addr = sel_data ? data_addr          : inst_addr;
    assign sel_type = sel_data ? data_transfer_type : inst_transfer_type;

    // ce of whichever port owns the current transaction
    assign owner_ce = owner_data ? data_ce : inst_ce;

    // channel valids and readies follow the state directly
    assign ar_valid = (state == st_ar_send);
    assign rd_ready = (state == st_r_recv);
    assign aw_valid = (state == st_aw_send);
    assign wd_valid = (state == st_w_send);
    assign wr_ready = (state == st_b_wait);

    assign ar_fire = ar_valid & ar_ready;
    assign aw_fire = aw_valid & aw_ready;
    assign wd_fire = wd_valid & wd_ready;
    assign rd_fire = rd_ready & rd_valid;

    // one shared address register for both address channels
    assign ar_addr = req_addr;
    assign aw_addr = req_addr;
    assign ar_len  = req_len;
    assign aw_len  = req_len;

    // last flag only counts inside the data phase
    assign wd_last = beat_last & (state == st_w_send);

    // read beats go to the owner only
    assign data_rdata_valid = rd_fire &  owner_data;
    assign inst_rdata_valid = rd_fire & ~owner_data;

    // write response is the acknowledge
    assign data_write_finish = wr_ready & wr_valid &  owner_data;
    assign inst_write_finish = wr_ready & wr_valid & ~owner_data;

    // buffer and counter load on the aw handshake
    assign line_load  = aw_fire;
    assign line_shift = wd_fire;
    assign load_line  = owner_data ? data_wdata : inst_wdata;
    assign load_mask  = owner_data ? data_wmask : inst_wmask;
    assign load_len   = req_len;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (grant) begin
                    state_next = sel_we ? st_aw_send : st_ar_send;
                end
            end
            st_ar_send: begin
                if (ar_fire) begin
                    state_next = st_r_recv;
                end
            end
            st_r_recv: begin
                // last beat is the read acknowledge
                if (rd_fire && rd_last) begin
                    state_next = st_release;
                end
            end
            st_aw_send: begin
                if (aw_fire) begin
                    state_next = st_w_send;
                end
            end
            st_w_send: begin
                if (wd_fire && beat_last) begin
                    state_next = st_b_wait;
                end
            end
            st_b_wait: begin
                if (wr_valid) begin
                    state_next = st_release;
                end
            end
            st_release: begin
                // four-phase return, wait for ce low
                if (!owner_ce) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!reset) begin
            state      <= st_idle;
            owner_data <= 1'b0;
        end else begin
            state <= state_next;
            if (state == st_idle && grant) begin
                owner_data <= sel_data;
            end
        end
    end

    // address and length captured once, held through back-pressure
    always_ff @(posedge aclk) begin
        if (state == st_idle && grant) begin
            req_addr <= sel_addr;
            req_len  <= (sel_type == XFER_LINE) ? LINE_LEN : WORD_LEN;
        end
    end

endmodule

/* src/axi_bridge_pkg.sv */
package axi_bridge_pkg;

    // bus and line geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int LINE_WIDTH     = 512;
    localparam int BEATS_PER_LINE = LINE_WIDTH / WORD_WIDTH;
    // one strobe bit per byte
    localparam int STRB_WIDTH     = WORD_WIDTH / 8;
    localparam int MASK_WIDTH     = LINE_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [MASK_WIDTH-1:0] line_mask_t;
    // axi len field, beats minus one
    typedef logic [7:0]            burst_len_t;
    typedef logic [2:0]            xfer_type_t;

    // requester code for a full line, anything else is one word
    localparam xfer_type_t XFER_LINE = 3'b100;
    localparam burst_len_t LINE_LEN  = burst_len_t'(BEATS_PER_LINE - 1);
    localparam burst_len_t WORD_LEN  = '0;

    typedef enum logic [2:0] {
        st_idle,
        st_ar_send,
        st_r_recv,
        st_aw_send,
        st_w_send,
        st_b_wait,
        st_release
    } bridge_state_t;

endpackage
